/* dcacheTop.f */
dcachePkg.sv
refillBuffer.sv
dcacheTagArray.sv
dcacheDataArray.sv
dcacheCtrl.sv
dcacheTop.sv
memModel.sv
dcacheTb.sv

/* runSim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dcacheTb -f dcacheTop.f -o simv

output=$(./obj_dir/simv)
echo "$output"

if grep -qF '*** TEST PASSED ***' <<< "$output"; then
  exit 0
else
  exit 1
fi

/* dcacheTb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheTb
  import dcachePkg::*;
();

  // roughly 300 requests at worst-case miss latency, with margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int RANDOM_REQS = 240;

  logic clk;
  logic rst_n;
  logic reqValid;
  logic reqWrite;
  logic [ADDR_W-1:0] reqAddr;
  logic [XLEN-1:0] reqWrData;
  logic [MASK_W-1:0] reqWrMask;
  logic reqReady;
  logic respValid;
  logic [XLEN-1:0] respRdData;
  logic memRdValid;
  logic [ADDR_W-1:0] memRdAddr;
  logic memRdReady;
  logic memDataValid;
  logic [XLEN-1:0] memRdData;
  logic memRdLast;
  logic memWrValid;
  logic [ADDR_W-1:0] memWrAddr;
  logic [LINE_W-1:0] memWrData;
  logic memWrReady;
  logic [31:0] rdCount;

  // architectural memory and tag state model
  logic [7:0] refMem [65536];
  logic [TAG_W-1:0] refTag [NUM_WAYS][NUM_SETS];
  logic refValid [NUM_WAYS][NUM_SETS];
  logic refDirty [NUM_WAYS][NUM_SETS];
  logic refRepl [NUM_SETS];

  // expectations for the request in flight
  logic expLoad;
  logic expHit;
  logic expWb;
  logic [ADDR_W-1:0] expWbAddr;
  logic [LINE_W-1:0] expWbLine;
  logic [ADDR_W-1:0] expRdAddr;
  logic [XLEN-1:0] expWord;

  int cycle = 0;
  int acceptCycle = 0;
  logic [31:0] rdAtAccept = '0;
  int wbTotal = 0;
  int wbAtAccept = 0;
  int respTotal = 0;
  int errors = 0;
  int checksRun = 0;
  logic idleChecked = 1'b0;
  int errBefore = 0;
  logic [ADDR_W-1:0] randAddr;

  dcacheTop dut_i (
    .clk, .rst_n,
    .reqValid_i(reqValid), .reqWrite_i(reqWrite), .reqAddr_i(reqAddr),
    .reqWrData_i(reqWrData), .reqWrMask_i(reqWrMask),
    .reqReady_o(reqReady), .respValid_o(respValid), .respRdData_o(respRdData),
    .memRdValid_o(memRdValid), .memRdAddr_o(memRdAddr), .memRdReady_i(memRdReady),
    .memDataValid_i(memDataValid), .memRdData_i(memRdData), .memRdLast_i(memRdLast),
    .memWrValid_o(memWrValid), .memWrAddr_o(memWrAddr), .memWrData_o(memWrData),
    .memWrReady_i(memWrReady)
  );

  memModel mem_i (
    .clk,
    .rdValid_i(memRdValid), .rdAddr_i(memRdAddr), .rdReady_o(memRdReady),
    .dataValid_o(memDataValid), .rdData_o(memRdData), .rdLast_o(memRdLast),
    .wrValid_i(memWrValid), .wrAddr_i(memWrAddr), .wrData_i(memWrData),
    .wrReady_o(memWrReady), .rdCount_o(rdCount)
  );

  function automatic logic [XLEN-1:0] patternWord(input logic [ADDR_W-1:0] a);
    return {a ^ 32'ha5c3_9e17, (a * 32'h0101_0101) ^ 32'h5a0f_3cc3};
  endfunction

  function automatic logic [LINE_W-1:0] refLine(input logic [ADDR_W-1:0] base);
    logic [LINE_W-1:0] line;
    for (int i = 0; i < LINE_W / 8; i++) begin
      line[i*8 +: 8] = refMem[base[15:0] + 16'(i)];
    end
    return line;
  endfunction

  // updates the model; returns the word as seen after the access
  function automatic logic [XLEN-1:0] refAccess(
    input logic write, input logic [ADDR_W-1:0] addr, input logic [XLEN-1:0] data,
    input logic [MASK_W-1:0] mask, output logic hit, output logic wb,
    output logic [ADDR_W-1:0] wbAddr, output logic [LINE_W-1:0] wbLine);
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic way;
    logic [15:0] wordBase;
    logic [XLEN-1:0] word;
    idx = addr[OFFSET_W +: INDEX_W];
    tag = addr[ADDR_W-1 -: TAG_W];
    wordBase = {addr[15:3], 3'b000};
    hit = 1'b0;
    wb = 1'b0;
    wbAddr = '0;
    wbLine = '0;
    way = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (refValid[w][idx] && refTag[w][idx] == tag) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (!hit) begin
      way = !refValid[0][idx] ? 1'b0 : (!refValid[1][idx] ? 1'b1 : refRepl[idx]);
      if (refValid[0][idx] && refValid[1][idx]) begin
        refRepl[idx] = ~refRepl[idx];
        if (refDirty[way][idx]) begin
          wb = 1'b1;
          wbAddr = {refTag[way][idx], idx, {OFFSET_W{1'b0}}};
          wbLine = refLine(wbAddr);
        end
      end
      refValid[way][idx] = 1'b1;
      refTag[way][idx] = tag;
      refDirty[way][idx] = 1'b0;
    end
    for (int b = 0; b < MASK_W; b++) begin
      if (write && mask[b]) begin
        refMem[wordBase + 16'(b)] = data[b*8 +: 8];
      end
      word[b*8 +: 8] = refMem[wordBase + 16'(b)];
    end
    if (write) begin
      refDirty[way][idx] = 1'b1;
    end
    return word;
  endfunction

  task automatic initReference();
    logic [XLEN-1:0] word;
    for (int a = 0; a < 65536; a += 8) begin
      word = patternWord(32'(a));
      for (int b = 0; b < 8; b++) begin
        refMem[16'(a + b)] = word[b*8 +: 8];
      end
    end
    for (int s = 0; s < NUM_SETS; s++) begin
      refRepl[s] = 1'b0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        refValid[w][s] = 1'b0;
        refDirty[w][s] = 1'b0;
        refTag[w][s] = '0;
      end
    end
  endtask

  task automatic checkValue(input string name, input logic [LINE_W-1:0] got,
                            input logic [LINE_W-1:0] exp);
    checksRun++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // called on a falling edge with the cache idle
  task automatic runRequest(input logic write, input logic [ADDR_W-1:0] addr,
                            input logic [XLEN-1:0] data, input logic [MASK_W-1:0] mask);
    int respBefore;
    logic hitPred;
    logic wbPred;
    logic [ADDR_W-1:0] wbAddr;
    logic [LINE_W-1:0] wbLine;
    expWord = refAccess(write, addr, data, mask, hitPred, wbPred, wbAddr, wbLine);
    expLoad = !write;
    expHit = hitPred;
    expWb = wbPred;
    expWbAddr = wbAddr;
    expWbLine = wbLine;
    expRdAddr = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    respBefore = respTotal;
    reqValid = 1'b1;
    reqWrite = write;
    reqAddr = addr;
    reqWrData = data;
    reqWrMask = mask;
    @(negedge clk);
    reqValid = 1'b0;
    while (respTotal == respBefore) @(negedge clk);
    while (!reqReady) @(negedge clk);
  endtask

  task automatic finishTest(input string name);
    $display("test %s done, %0d new errors", name, errors - errBefore);
    errBefore = errors;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // compares every handshake and response against the expectations
  always @(posedge clk) begin
    cycle++;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      if (rst_n && !idleChecked) begin
        idleChecked = 1'b1;
        checkValue("reqReady_o", 256'(reqReady), 256'(1));
        checkValue("respValid_o", 256'(respValid), 256'(0));
        checkValue("memRdValid_o", 256'(memRdValid), 256'(0));
        checkValue("memWrValid_o", 256'(memWrValid), 256'(0));
      end
      if (reqValid && reqReady) begin
        acceptCycle = cycle;
        rdAtAccept = rdCount;
        wbAtAccept = wbTotal;
      end
      if (memRdValid && memRdReady) begin
        checkValue("memRdAddr_o", 256'(memRdAddr), 256'(expRdAddr));
      end
      if (memWrValid && memWrReady) begin
        wbTotal++;
        checkValue("memWrAddr_o", 256'(memWrAddr), 256'(expWbAddr));
        checkValue("memWrData_o", memWrData, expWbLine);
      end
      if (respValid) begin
        if (expLoad) begin
          checkValue("respRdData_o", 256'(respRdData), 256'(expWord));
        end
        checkValue("memRdValid_o count", 256'(rdCount - rdAtAccept), 256'(!expHit));
        checkValue("memWrValid_o count", 256'(wbTotal - wbAtAccept), 256'(expWb));
        if (expHit) begin
          checkValue("respValid_o latency", 256'(cycle - acceptCycle), 256'(1));
        end
        respTotal++;
      end
    end
  end

  initial begin
    void'($urandom(32'h86a7_bee3));
    rst_n = 1'b0;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr = '0;
    reqWrData = '0;
    reqWrMask = '0;
    randAddr = '0;
    initReference();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    finishTest("reset state");

    runRequest(1'b0, 32'h0000_0028, '0, '0);
    runRequest(1'b0, 32'h0000_0030, '0, '0);
    finishTest("cold miss then hit");

    runRequest(1'b1, 32'h0000_0030, 64'h1122_3344_5566_7788, 8'b0011_0110);
    runRequest(1'b0, 32'h0000_0030, '0, '0);
    finishTest("masked store merge");

    // three tags in set 5, first one dirty
    runRequest(1'b1, 32'h0000_08a0, 64'hdead_beef_0bad_f00d, 8'hff);
    runRequest(1'b0, 32'h0000_10a8, '0, '0);
    runRequest(1'b0, 32'h0000_18b0, '0, '0);
    runRequest(1'b0, 32'h0000_08b8, '0, '0);
    finishTest("eviction and write-back");

    for (int n = 0; n < RANDOM_REQS; n++) begin
      randAddr = {16'h0000, 5'($urandom_range(7, 1)), 6'($urandom_range(10, 8)),
                  2'($urandom_range(3, 0)), 3'b000};
      runRequest(1'($urandom_range(1, 0)), randAddr, {$urandom, $urandom}, 8'($urandom));
    end
    finishTest("random mix");

    @(negedge clk);
    $display("summary: %0d checks, %0d errors", checksRun, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* memModel.sv */
`timescale 1ns/1ps
`default_nettype none

module memModel
  import dcachePkg::*;
(
  input  logic clk,
  input  logic rdValid_i,
  input  logic [ADDR_W-1:0] rdAddr_i,
  output logic rdReady_o,
  output logic dataValid_o,
  output logic [XLEN-1:0] rdData_o,
  output logic rdLast_o,
  input  logic wrValid_i,
  input  logic [ADDR_W-1:0] wrAddr_i,
  input  logic [LINE_W-1:0] wrData_i,
  output logic wrReady_o,
  output logic [31:0] rdCount_o
);

  // 64 KB held as 64-bit words
  localparam int WORDS = 8192;

  logic [XLEN-1:0] mem [WORDS];
  logic [ADDR_W-1:0] lineAddr;

  // each word is derived from its own byte address
  function automatic logic [XLEN-1:0] patternWord(input logic [ADDR_W-1:0] a);
    return {a ^ 32'ha5c3_9e17, (a * 32'h0101_0101) ^ 32'h5a0f_3cc3};
  endfunction

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = patternWord(32'(i * 8));
    end
    rdReady_o = 1'b0;
    dataValid_o = 1'b0;
    rdData_o = '0;
    rdLast_o = 1'b0;
    wrReady_o = 1'b0;
    rdCount_o = '0;
    lineAddr = '0;
    forever begin
      @(negedge clk);
      if (wrValid_i) begin
        repeat ($urandom_range(3, 0)) @(negedge clk);
        // line is held stable until ready, so take it now
        for (int w = 0; w < BEATS; w++) begin
          mem[wrAddr_i[15:3] + 13'(w)] = wrData_i[w*XLEN +: XLEN];
        end
        wrReady_o = 1'b1;
        @(negedge clk);
        wrReady_o = 1'b0;
      end else if (rdValid_i) begin
        rdCount_o = rdCount_o + 32'd1;
        lineAddr = rdAddr_i;
        repeat ($urandom_range(3, 0)) @(negedge clk);
        rdReady_o = 1'b1;
        @(negedge clk);
        rdReady_o = 1'b0;
        // beats in ascending word order with random gaps
        for (int b = 0; b < BEATS; b++) begin
          repeat ($urandom_range(3, 0)) @(negedge clk);
          dataValid_o = 1'b1;
          rdData_o = mem[lineAddr[15:3] + 13'(b)];
          rdLast_o = (b == BEATS - 1);
          @(negedge clk);
          dataValid_o = 1'b0;
          rdLast_o = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dcacheTop.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheTop
  import dcachePkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic reqValid_i,
  input  logic reqWrite_i,
  input  logic [ADDR_W-1:0] reqAddr_i,
  input  logic [XLEN-1:0] reqWrData_i,
  input  logic [MASK_W-1:0] reqWrMask_i,
  output logic reqReady_o,
  output logic respValid_o,
  output logic [XLEN-1:0] respRdData_o,
  output logic memRdValid_o,
  output logic [ADDR_W-1:0] memRdAddr_o,
  input  logic memRdReady_i,
  input  logic memDataValid_i,
  input  logic [XLEN-1:0] memRdData_i,
  input  logic memRdLast_i,
  output logic memWrValid_o,
  output logic [ADDR_W-1:0] memWrAddr_o,
  output logic [LINE_W-1:0] memWrData_o,
  input  logic memWrReady_i
);

  cacheAddrT lookupAddr;
  logic selWay;
  logic installEn;
  logic markDirty;
  logic fillEn;
  logic wordWrEn;
  logic [XLEN-1:0] wordWrData;
  logic [MASK_W-1:0] wordWrMask;
  logic hit;
  logic hitWay;
  logic victimWay;
  logic victimDirty;
  logic [TAG_W-1:0] victimTag;
  logic [LINE_W-1:0] selLine;
  logic [LINE_W-1:0] fillLine;

  // victim way is selected during write-back
  assign memWrData_o = selLine;

  dcacheCtrl ctrl_i (
    .clk, .rst_n,
    .reqValid_i, .reqWrite_i, .reqAddr_i, .reqWrData_i, .reqWrMask_i,
    .memRdReady_i, .memDataValid_i, .memRdLast_i, .memWrReady_i,
    .hit_i(hit), .hitWay_i(hitWay), .victimWay_i(victimWay),
    .victimDirty_i(victimDirty), .victimTag_i(victimTag), .selLine_i(selLine),
    .reqReady_o, .respValid_o, .respRdData_o,
    .memRdValid_o, .memRdAddr_o, .memWrValid_o, .memWrAddr_o,
    .lookupAddr_o(lookupAddr), .selWay_o(selWay),
    .installEn_o(installEn), .markDirty_o(markDirty), .fillEn_o(fillEn),
    .wordWrEn_o(wordWrEn), .wordWrData_o(wordWrData), .wordWrMask_o(wordWrMask)
  );

  dcacheTagArray tags_i (
    .clk, .rst_n,
    .lookupAddr_i(lookupAddr), .installEn_i(installEn),
    .installWay_i(selWay), .markDirty_i(markDirty),
    .hit_o(hit), .hitWay_o(hitWay), .victimWay_o(victimWay),
    .victimDirty_o(victimDirty), .victimTag_o(victimTag)
  );

  dcacheDataArray data_i (
    .clk,
    .index_i(lookupAddr.f.index), .selWay_i(selWay),
    .installEn_i(installEn), .fillLine_i(fillLine),
    .wordWrEn_i(wordWrEn), .wordSel_i(lookupAddr.f.offset[OFFSET_W-1 -: WORD_SEL_W]),
    .wordWrData_i(wordWrData), .wordWrMask_i(wordWrMask),
    .selLine_o(selLine)
  );

  refillBuffer refill_i (
    .clk, .rst_n,
    .fillEn_i(fillEn), .beatValid_i(memDataValid_i),
    .beatData_i(memRdData_i), .beatLast_i(memRdLast_i),
    .line_o(fillLine)
  );

endmodule

`default_nettype wire

/* dcacheCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheCtrl
  import dcachePkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic reqValid_i,
  input  logic reqWrite_i,
  input  logic [ADDR_W-1:0] reqAddr_i,
  input  logic [XLEN-1:0] reqWrData_i,
  input  logic [MASK_W-1:0] reqWrMask_i,
  input  logic memRdReady_i,
  input  logic memDataValid_i,
  input  logic memRdLast_i,
  input  logic memWrReady_i,
  input  logic hit_i,
  input  logic hitWay_i,
  input  logic victimWay_i,
  input  logic victimDirty_i,
  input  logic [TAG_W-1:0] victimTag_i,
  input  logic [LINE_W-1:0] selLine_i,
  output logic reqReady_o,
  output logic respValid_o,
  output logic [XLEN-1:0] respRdData_o,
  output logic memRdValid_o,
  output logic [ADDR_W-1:0] memRdAddr_o,
  output logic memWrValid_o,
  output logic [ADDR_W-1:0] memWrAddr_o,
  output cacheAddrT lookupAddr_o,
  output logic selWay_o,
  output logic installEn_o,
  output logic markDirty_o,
  output logic fillEn_o,
  output logic wordWrEn_o,
  output logic [XLEN-1:0] wordWrData_o,
  output logic [MASK_W-1:0] wordWrMask_o
);

  logic [STATE_W-1:0] state;
  logic [STATE_W-1:0] nextState;
  logic reqWrite;
  cacheAddrT reqAddr;
  logic [XLEN-1:0] reqWrData;
  logic [MASK_W-1:0] reqWrMask;
  logic [WORD_SEL_W-1:0] wordSel;

  assign wordSel = reqAddr.f.offset[OFFSET_W-1 -: WORD_SEL_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      ST_IDLE: begin
        if (reqValid_i) begin
          nextState = ST_COMPARE;
        end
      end
      ST_COMPARE: begin
        if (hit_i) begin
          nextState = ST_IDLE;
        end else if (victimDirty_i) begin
          nextState = ST_WRITE_BACK;
        end else begin
          nextState = ST_FETCH;
        end
      end
      // dirty victim leaves before the refill is requested
      ST_WRITE_BACK: begin
        if (memWrReady_i) begin
          nextState = ST_FETCH;
        end
      end
      ST_FETCH: begin
        if (memRdReady_i) begin
          nextState = ST_FILL;
        end
      end
      ST_FILL: begin
        if (memDataValid_i && memRdLast_i) begin
          nextState = ST_INSTALL;
        end
      end
      // back to compare, which now hits
      ST_INSTALL: nextState = ST_COMPARE;
      default: nextState = ST_IDLE;
    endcase
  end

  // request latch, taken only in idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqWrite <= 1'b0;
      reqAddr.raw <= '0;
    end else if (reqValid_i && reqReady_o) begin
      reqWrite <= reqWrite_i;
      reqAddr.raw <= reqAddr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reqValid_i && reqReady_o) begin
      reqWrData <= reqWrData_i;
      reqWrMask <= reqWrMask_i;
    end
  end

  assign reqReady_o = (state == ST_IDLE);
  assign respValid_o = (state == ST_COMPARE) && hit_i;
  assign respRdData_o = selLine_i[wordSel*XLEN +: XLEN];

  // line-aligned addresses for both memory directions
  assign memRdValid_o = (state == ST_FETCH);
  assign memRdAddr_o = {reqAddr.f.tag, reqAddr.f.index, {OFFSET_W{1'b0}}};
  assign memWrValid_o = (state == ST_WRITE_BACK);
  assign memWrAddr_o = {victimTag_i, reqAddr.f.index, {OFFSET_W{1'b0}}};

  assign lookupAddr_o = reqAddr;
  assign selWay_o = (state == ST_COMPARE) ? hitWay_i : victimWay_i;
  assign installEn_o = (state == ST_INSTALL);
  assign fillEn_o = (state == ST_FILL);

  // store hit merges the word and marks the line dirty
  assign wordWrEn_o = (state == ST_COMPARE) && hit_i && reqWrite;
  assign markDirty_o = wordWrEn_o;
  assign wordWrData_o = reqWrData;
  assign wordWrMask_o = reqWrMask;

  // victim tag must not move while the write-back waits
  wrStrobeHeld: assert property (
    @(posedge clk) disable iff (!rst_n)
    memWrValid_o && !memWrReady_i |=> memWrValid_o && $stable(memWrAddr_o));

  // the installed line has to hit on the retry
  hitAfterInstall: assert property (
    @(posedge clk) disable iff (!rst_n) state == ST_INSTALL |=> hit_i);

endmodule

`default_nettype wire

/* dcacheDataArray.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheDataArray
  import dcachePkg::*;
(
  input  logic clk,
  input  logic [INDEX_W-1:0] index_i,
  input  logic selWay_i,
  input  logic installEn_i,
  input  logic [LINE_W-1:0] fillLine_i,
  input  logic wordWrEn_i,
  input  logic [WORD_SEL_W-1:0] wordSel_i,
  input  logic [XLEN-1:0] wordWrData_i,
  input  logic [MASK_W-1:0] wordWrMask_i,
  output logic [LINE_W-1:0] selLine_o
);

  logic [LINE_W-1:0] lines [NUM_WAYS][NUM_SETS];
  logic [LINE_W-1:0] mergedLine;

  // async read, a write shows up the next cycle
  assign selLine_o = lines[selWay_i][index_i];

  // byte merge of the store into the current line
  always_comb begin
    mergedLine = selLine_o;
    for (int b = 0; b < MASK_W; b++) begin
      if (wordWrMask_i[b]) begin
        mergedLine[wordSel_i*XLEN + b*8 +: 8] = wordWrData_i[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (installEn_i) begin
      lines[selWay_i][index_i] <= fillLine_i;
    end else if (wordWrEn_i) begin
      lines[selWay_i][index_i] <= mergedLine;
    end
  end

endmodule

`default_nettype wire

/* dcacheTagArray.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheTagArray
  import dcachePkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  cacheAddrT lookupAddr_i,
  input  logic installEn_i,
  input  logic installWay_i,
  input  logic markDirty_i,
  output logic hit_o,
  output logic hitWay_o,
  output logic victimWay_o,
  output logic victimDirty_o,
  output logic [TAG_W-1:0] victimTag_o
);

  logic [TAG_W-1:0] tags [NUM_WAYS][NUM_SETS];
  logic [NUM_WAYS-1:0][NUM_SETS-1:0] validBits;
  logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirtyBits;
  logic [NUM_SETS-1:0] replBits;
  logic [INDEX_W-1:0] idx;
  logic [NUM_WAYS-1:0] setValid;
  logic [NUM_WAYS-1:0] wayHit;

  assign idx = lookupAddr_i.f.index;

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      setValid[w] = validBits[w][idx];
      wayHit[w] = validBits[w][idx] && (tags[w][idx] == lookupAddr_i.f.tag);
    end
  end

  assign hit_o = |wayHit;
  assign hitWay_o = wayHit[1];

  // free way first, then the set's replacement bit
  assign victimWay_o = !setValid[0] ? 1'b0 : (!setValid[1] ? 1'b1 : replBits[idx]);
  assign victimDirty_o = dirtyBits[victimWay_o][idx];
  assign victimTag_o = tags[victimWay_o][idx];

  always_ff @(posedge clk) begin
    if (installEn_i) begin
      tags[installWay_i][idx] <= lookupAddr_i.f.tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
      dirtyBits <= '0;
      replBits <= '0;
    end else if (installEn_i) begin
      validBits[installWay_i][idx] <= 1'b1;
      dirtyBits[installWay_i][idx] <= 1'b0;
      // flip only when a full set loses a line
      if (&setValid) begin
        replBits[idx] <= ~replBits[idx];
      end
    end else if (markDirty_i) begin
      dirtyBits[hitWay_o][idx] <= 1'b1;
    end
  end

  noDoubleHit: assert property (
    @(posedge clk) disable iff (!rst_n) !(&wayHit));

endmodule

`default_nettype wire

/* refillBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module refillBuffer
  import dcachePkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic fillEn_i,
  input  logic beatValid_i,
  input  logic [XLEN-1:0] beatData_i,
  input  logic beatLast_i,
  output logic [LINE_W-1:0] line_o
);

  logic [WORD_SEL_W-1:0] beatCnt;
  logic beatTake;

  assign beatTake = fillEn_i && beatValid_i;

  // wraps to zero after the fourth beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatTake) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (beatTake) begin
      line_o[beatCnt*XLEN +: XLEN] <= beatData_i;
    end
  end

  lastOnFinalBeat: assert property (
    @(posedge clk) disable iff (!rst_n)
    beatTake && beatLast_i |-> beatCnt == WORD_SEL_W'(BEATS - 1));

endmodule

`default_nettype wire

/* dcachePkg.sv */
`default_nettype none

package dcachePkg;

  // request and bus widths
  localparam int ADDR_W = 32;
  localparam int XLEN = 64;
  localparam int MASK_W = XLEN / 8;

  // line geometry
  localparam int LINE_W = 256;
  localparam int BEATS = LINE_W / XLEN;
  localparam int NUM_SETS = 64;
  localparam int NUM_WAYS = 2;
  localparam int INDEX_W = 6;
  localparam int OFFSET_W = 5;
  // word index sits in offset bits 4..3
  localparam int WORD_SEL_W = 2;
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  // controller state encoding
  localparam int STATE_W = 3;
  localparam logic [STATE_W-1:0] ST_IDLE = 3'd0;
  localparam logic [STATE_W-1:0] ST_COMPARE = 3'd1;
  localparam logic [STATE_W-1:0] ST_WRITE_BACK = 3'd2;
  localparam logic [STATE_W-1:0] ST_FETCH = 3'd3;
  localparam logic [STATE_W-1:0] ST_FILL = 3'd4;
  localparam logic [STATE_W-1:0] ST_INSTALL = 3'd5;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [INDEX_W-1:0] index;
    logic [OFFSET_W-1:0] offset;
  } addrFieldsT;

  // raw view for memory addresses, field view for lookup
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    addrFieldsT f;
  } cacheAddrT;

endpackage

`default_nettype wire
